//--- include/rv_params.svh
// rv64i decode constants
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// widths
`define XLEN        64
`define INST_WD     32
`define GPR_ADDR_WD 5

// major opcodes
`define OPC_OP_IMM  7'b0010011
`define OPC_OP      7'b0110011
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_BRANCH  7'b1100011
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111

// funct3
`define F3_ADD      3'b000
`define F3_BEQ      3'b000
`define F3_BNE      3'b001
`define F3_BLT      3'b100
`define F3_BGE      3'b101
`define F3_LD       3'b011
`define F3_SD       3'b011
`define F3_JALR     3'b000

// funct7, add vs sub
`define F7_ADD      7'b0000000
`define F7_SUB      7'b0100000

`endif

//--- logic/rv_decode_pkg.sv
// decode stage types
`include "rv_params.svh"

package rv_decode_pkg;

  typedef logic [`XLEN-1:0]        xlen_t;
  typedef logic [`INST_WD-1:0]     inst_t;
  typedef logic [`GPR_ADDR_WD-1:0] gpr_addr_t;

  typedef enum logic [4:0] {
    alu_add    = 5'd0,
    alu_sub    = 5'd1,
    alu_pass_b = 5'd2  // no arithmetic, operand b passes through
  } alu_op_e;

  typedef enum logic {
    src1_rs1 = 1'b0,
    src1_pc  = 1'b1
  } src1_sel_e;

  typedef enum logic [1:0] {
    src2_rs2  = 2'd0,
    src2_imm  = 2'd1,
    src2_four = 2'd2   // link address pc + 4
  } src2_sel_e;

  // same encoding as funct3 of loads and stores
  typedef enum logic [2:0] {
    mem_b  = 3'b000,
    mem_h  = 3'b001,
    mem_w  = 3'b010,
    mem_d  = 3'b011,
    mem_bu = 3'b100,
    mem_hu = 3'b101,
    mem_wu = 3'b110
  } mem_op_e;

  typedef enum logic [2:0] {
    br_none = 3'd0,
    br_eq   = 3'd1,
    br_ne   = 3'd2,
    br_lt   = 3'd3,
    br_ge   = 3'd4,
    br_jump = 3'd5,  // jal, pc relative
    br_jalr = 3'd6   // jalr, rs1 relative
  } br_func_e;

endpackage

//--- logic/id_latch.sv
// decode stage latch
`timescale 1ns/10ps

module id_latch (
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  input  logic                  i_fs_to_ds_valid,
  input  rv_decode_pkg::inst_t  i_fs_inst,
  input  rv_decode_pkg::xlen_t  i_fs_pc,
  input  logic                  i_es_allowin,
  input  logic                  i_load_stall,
  output logic                  o_ds_valid,
  output rv_decode_pkg::inst_t  o_inst,
  output rv_decode_pkg::xlen_t  o_pc,
  output logic                  o_ds_allowin,
  output logic                  o_ds_to_es_valid
);

  logic ds_ready_go;

  assign ds_ready_go      = ~i_load_stall;  // only a load-use hazard holds us
  assign o_ds_allowin     = ~o_ds_valid | (ds_ready_go & i_es_allowin);
  assign o_ds_to_es_valid = o_ds_valid & ds_ready_go;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      o_ds_valid <= i_fs_to_ds_valid;  // empties when fetch has nothing
    end
  end

  // payload loads only on a real transfer
  always_ff @(posedge i_clk) begin
    if (i_fs_to_ds_valid && o_ds_allowin) begin
      o_inst <= i_fs_inst;
      o_pc   <= i_fs_pc;
    end
  end

  // an offered but refused instruction stays put for the next cycle
  a_hold_on_backpressure: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    (o_ds_to_es_valid && !i_es_allowin) |=>
      (o_ds_valid && $stable(o_inst) && $stable(o_pc))
  ) else $error("decode latch lost a refused instruction");

endmodule

//--- logic/idu.sv
// rv64i subset decoder
`timescale 1ns/10ps
`include "rv_params.svh"

module idu (
  input  rv_decode_pkg::inst_t       i_inst,
  output rv_decode_pkg::gpr_addr_t   o_rs1,
  output rv_decode_pkg::gpr_addr_t   o_rs2,
  output rv_decode_pkg::gpr_addr_t   o_rd,
  output logic                       o_rs1_used,
  output logic                       o_rs2_used,
  output rv_decode_pkg::xlen_t       o_imm,
  output rv_decode_pkg::alu_op_e     o_alu_op,
  output rv_decode_pkg::src1_sel_e   o_src1_sel,
  output rv_decode_pkg::src2_sel_e   o_src2_sel,
  output logic                       o_gpr_wen,
  output logic                       o_mem_ren,
  output logic                       o_mem_wen,
  output rv_decode_pkg::mem_op_e     o_mem_op,
  output logic                       o_load_sel,
  output rv_decode_pkg::br_func_e    o_br_func,
  output logic                       o_invalid_inst
);

  logic [6:0]            opcode;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  rv_decode_pkg::xlen_t  imm_i;
  rv_decode_pkg::xlen_t  imm_s;
  rv_decode_pkg::xlen_t  imm_b;
  rv_decode_pkg::xlen_t  imm_j;
  logic                  gpr_wen;
  logic                  mem_ren;
  logic                  mem_wen;
  logic                  load_sel;
  logic                  bad;
  rv_decode_pkg::br_func_e br_func;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];
  assign o_rs1  = i_inst[19:15];
  assign o_rs2  = i_inst[24:20];

  assign imm_i = {{(`XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{(`XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{(`XLEN-13){i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                  i_inst[11:8], 1'b0};
  assign imm_j = {{(`XLEN-21){i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                  i_inst[30:21], 1'b0};

  always_comb begin
    o_rs1_used = 1'b0;
    o_rs2_used = 1'b0;
    o_imm      = '0;
    o_alu_op   = rv_decode_pkg::alu_pass_b;  // branches leave the alu idle
    o_src1_sel = rv_decode_pkg::src1_rs1;
    o_src2_sel = rv_decode_pkg::src2_rs2;
    o_mem_op   = rv_decode_pkg::mem_b;
    gpr_wen    = 1'b0;
    mem_ren    = 1'b0;
    mem_wen    = 1'b0;
    load_sel   = 1'b0;
    br_func    = rv_decode_pkg::br_none;
    bad        = 1'b0;
    case (opcode)
      `OPC_OP_IMM: begin  // addi
        bad        = (funct3 != `F3_ADD);
        o_rs1_used = 1'b1;
        o_imm      = imm_i;
        o_src2_sel = rv_decode_pkg::src2_imm;
        o_alu_op   = rv_decode_pkg::alu_add;
        gpr_wen    = 1'b1;
      end
      `OPC_OP: begin
        bad        = (funct3 != `F3_ADD) || ((funct7 != `F7_ADD) && (funct7 != `F7_SUB));
        o_rs1_used = 1'b1;
        o_rs2_used = 1'b1;
        o_alu_op   = (funct7 == `F7_SUB) ? rv_decode_pkg::alu_sub : rv_decode_pkg::alu_add;
        gpr_wen    = 1'b1;
      end
      `OPC_LOAD: begin  // ld only
        bad        = (funct3 != `F3_LD);
        o_rs1_used = 1'b1;
        o_imm      = imm_i;
        o_src2_sel = rv_decode_pkg::src2_imm;
        o_alu_op   = rv_decode_pkg::alu_add;
        o_mem_op   = rv_decode_pkg::mem_op_e'(funct3);
        gpr_wen    = 1'b1;
        mem_ren    = 1'b1;
        load_sel   = 1'b1;
      end
      `OPC_STORE: begin  // sd only
        bad        = (funct3 != `F3_SD);
        o_rs1_used = 1'b1;
        o_rs2_used = 1'b1;
        o_imm      = imm_s;
        o_src2_sel = rv_decode_pkg::src2_imm;
        o_alu_op   = rv_decode_pkg::alu_add;
        o_mem_op   = rv_decode_pkg::mem_op_e'(funct3);
        mem_wen    = 1'b1;
      end
      `OPC_BRANCH: begin
        o_rs1_used = 1'b1;
        o_rs2_used = 1'b1;
        o_imm      = imm_b;
        case (funct3)
          `F3_BEQ: br_func = rv_decode_pkg::br_eq;
          `F3_BNE: br_func = rv_decode_pkg::br_ne;
          `F3_BLT: br_func = rv_decode_pkg::br_lt;
          `F3_BGE: br_func = rv_decode_pkg::br_ge;
          default: bad = 1'b1;
        endcase
      end
      `OPC_JAL, `OPC_JALR: begin  // both link pc + 4
        bad        = (opcode == `OPC_JALR) && (funct3 != `F3_JALR);
        o_rs1_used = (opcode == `OPC_JALR);
        o_imm      = (opcode == `OPC_JALR) ? imm_i : imm_j;
        o_src1_sel = rv_decode_pkg::src1_pc;
        o_src2_sel = rv_decode_pkg::src2_four;
        o_alu_op   = rv_decode_pkg::alu_add;
        gpr_wen    = 1'b1;
        br_func    = (opcode == `OPC_JALR) ? rv_decode_pkg::br_jalr : rv_decode_pkg::br_jump;
      end
      default: bad = 1'b1;
    endcase
  end

  // an invalid instruction must not write anything or redirect fetch
  assign o_invalid_inst = bad;
  assign o_gpr_wen      = gpr_wen & ~bad;
  assign o_mem_ren      = mem_ren & ~bad;
  assign o_mem_wen      = mem_wen & ~bad;
  assign o_load_sel     = load_sel & ~bad;
  assign o_br_func      = bad ? rv_decode_pkg::br_none : br_func;
  assign o_rd           = o_gpr_wen ? i_inst[11:7] : '0;  // rd 0 when nothing is written

endmodule

//--- logic/gpr_file.sv
// general register file
`timescale 1ns/10ps

module gpr_file (
  input  logic                       i_clk,
  // read ports
  input  rv_decode_pkg::gpr_addr_t   i_raddr1,
  output rv_decode_pkg::xlen_t       o_rdata1,
  input  rv_decode_pkg::gpr_addr_t   i_raddr2,
  output rv_decode_pkg::xlen_t       o_rdata2,
  // write back port
  input  logic                       i_wen,
  input  rv_decode_pkg::gpr_addr_t   i_waddr,
  input  rv_decode_pkg::xlen_t       i_wdata
);

  localparam int NUM_REGS = 1 << $bits(rv_decode_pkg::gpr_addr_t);

  rv_decode_pkg::xlen_t regs [NUM_REGS];

  always_ff @(posedge i_clk) begin
    if (i_wen && (i_waddr != '0)) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // x0 hardwired to zero
  // same-cycle writes reach decode through the ws bypass
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

//--- logic/bypass_unit.sv
// operand forwarding and load-use detect
`timescale 1ns/10ps

module bypass_unit (
  input  logic                       i_clk,
  input  logic                       i_rst_n,
  input  logic                       i_ds_valid,
  input  rv_decode_pkg::gpr_addr_t   i_rs1,
  input  rv_decode_pkg::gpr_addr_t   i_rs2,
  input  logic                       i_rs1_used,
  input  logic                       i_rs2_used,
  input  rv_decode_pkg::xlen_t       i_rf_data1,
  input  rv_decode_pkg::xlen_t       i_rf_data2,
  input  rv_decode_pkg::gpr_addr_t   i_es_rd,
  input  rv_decode_pkg::xlen_t       i_es_result,
  input  rv_decode_pkg::gpr_addr_t   i_ms_rd,
  input  rv_decode_pkg::xlen_t       i_ms_result,
  input  rv_decode_pkg::gpr_addr_t   i_ws_rd,
  input  rv_decode_pkg::xlen_t       i_ws_result,
  input  logic                       i_es_load_sel,
  output rv_decode_pkg::xlen_t       o_rs1_data,
  output rv_decode_pkg::xlen_t       o_rs2_data,
  output logic                       o_load_stall
);

  // youngest producer wins and rd 0 never forwards
  function automatic rv_decode_pkg::xlen_t fwd(
    input rv_decode_pkg::gpr_addr_t rs,
    input rv_decode_pkg::xlen_t     rf_data,
    input rv_decode_pkg::gpr_addr_t es_rd,
    input rv_decode_pkg::xlen_t     es_result,
    input rv_decode_pkg::gpr_addr_t ms_rd,
    input rv_decode_pkg::xlen_t     ms_result,
    input rv_decode_pkg::gpr_addr_t ws_rd,
    input rv_decode_pkg::xlen_t     ws_result
  );
    if ((es_rd != '0) && (rs == es_rd)) return es_result;
    if ((ms_rd != '0) && (rs == ms_rd)) return ms_result;
    if ((ws_rd != '0) && (rs == ws_rd)) return ws_result;
    return rf_data;
  endfunction

  logic rs1_hit_es;
  logic rs2_hit_es;

  assign o_rs1_data = fwd(i_rs1, i_rf_data1, i_es_rd, i_es_result, i_ms_rd, i_ms_result,
                          i_ws_rd, i_ws_result);
  assign o_rs2_data = fwd(i_rs2, i_rf_data2, i_es_rd, i_es_result, i_ms_rd, i_ms_result,
                          i_ws_rd, i_ws_result);

  assign rs1_hit_es = i_rs1_used && (i_rs1 == i_es_rd);
  assign rs2_hit_es = i_rs2_used && (i_rs2 == i_es_rd);

  // load data only exists once it reaches mem
  assign o_load_stall = i_ds_valid && i_es_load_sel && (i_es_rd != '0) &&
                        (rs1_hit_es || rs2_hit_es);

  // the latch must keep the stalled instruction for the following cycle
  a_stall_holds_inst: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    o_load_stall |-> i_es_load_sel ##1 (i_ds_valid && $stable(i_rs1) && $stable(i_rs2))
  ) else $error("load-use stall without a held instruction");

endmodule

//--- logic/bru.sv
// branch resolve unit
`timescale 1ns/10ps

module bru (
  input  logic                       i_ds_valid,
  input  rv_decode_pkg::br_func_e    i_br_func,
  input  rv_decode_pkg::xlen_t       i_rs1_data,
  input  rv_decode_pkg::xlen_t       i_rs2_data,
  input  rv_decode_pkg::xlen_t       i_pc,
  input  rv_decode_pkg::xlen_t       i_imm,
  input  logic                       i_load_stall,
  output logic                       o_br_taken,
  output rv_decode_pkg::xlen_t       o_br_target,
  output logic                       o_br_stall
);

  logic                  cond;
  rv_decode_pkg::xlen_t  jalr_sum;

  always_comb begin
    case (i_br_func)
      rv_decode_pkg::br_eq:   cond = (i_rs1_data == i_rs2_data);
      rv_decode_pkg::br_ne:   cond = (i_rs1_data != i_rs2_data);
      rv_decode_pkg::br_lt:   cond = ($signed(i_rs1_data) <  $signed(i_rs2_data));
      rv_decode_pkg::br_ge:   cond = ($signed(i_rs1_data) >= $signed(i_rs2_data));
      rv_decode_pkg::br_jump,
      rv_decode_pkg::br_jalr: cond = 1'b1;
      default:                cond = 1'b0;
    endcase
  end

  assign jalr_sum = i_rs1_data + i_imm;

  assign o_br_target = (i_br_func == rv_decode_pkg::br_jalr) ?
                       {jalr_sum[$bits(jalr_sum)-1:1], 1'b0} :  // lsb cleared
                       i_pc + i_imm;

  assign o_br_taken = i_ds_valid & cond;
  assign o_br_stall = i_load_stall & o_br_taken;  // fetch waits for stale operand

endmodule

//--- logic/id_stage.sv
// decode stage top
`timescale 1ns/10ps

module id_stage (
  input  logic                       i_clk,
  input  logic                       i_rst_n,
  // from fetch
  input  logic                       i_fs_to_ds_valid,
  input  rv_decode_pkg::inst_t       i_fs_inst,
  input  rv_decode_pkg::xlen_t       i_fs_pc,
  output logic                       o_ds_allowin,
  // to execute
  input  logic                       i_es_allowin,
  output logic                       o_ds_to_es_valid,
  output rv_decode_pkg::xlen_t       o_rs1_data,
  output rv_decode_pkg::xlen_t       o_rs2_data,
  output rv_decode_pkg::xlen_t       o_imm,
  output rv_decode_pkg::xlen_t       o_pc,
  output rv_decode_pkg::gpr_addr_t   o_rd,
  output rv_decode_pkg::alu_op_e     o_alu_op,
  output rv_decode_pkg::src1_sel_e   o_src1_sel,
  output rv_decode_pkg::src2_sel_e   o_src2_sel,
  output logic                       o_gpr_wen,
  output logic                       o_mem_ren,
  output logic                       o_mem_wen,
  output rv_decode_pkg::mem_op_e     o_mem_op,
  output logic                       o_load_sel,
  output logic                       o_invalid_inst,
  // write back port
  input  logic                       i_rf_wen,
  input  rv_decode_pkg::gpr_addr_t   i_rf_waddr,
  input  rv_decode_pkg::xlen_t       i_rf_wdata,
  // bypass from later stages
  input  rv_decode_pkg::gpr_addr_t   i_es_rd,
  input  rv_decode_pkg::xlen_t       i_es_result,
  input  rv_decode_pkg::gpr_addr_t   i_ms_rd,
  input  rv_decode_pkg::xlen_t       i_ms_result,
  input  rv_decode_pkg::gpr_addr_t   i_ws_rd,
  input  rv_decode_pkg::xlen_t       i_ws_result,
  input  logic                       i_es_load_sel,
  // to fetch
  output logic                       o_br_taken,
  output logic                       o_br_stall,
  output rv_decode_pkg::xlen_t       o_br_target
);

  logic                      ds_valid;
  logic                      load_stall;
  rv_decode_pkg::inst_t      ds_inst;
  rv_decode_pkg::gpr_addr_t  rs1;
  rv_decode_pkg::gpr_addr_t  rs2;
  logic                      rs1_used;
  logic                      rs2_used;
  rv_decode_pkg::xlen_t      rf_rdata1;
  rv_decode_pkg::xlen_t      rf_rdata2;
  rv_decode_pkg::br_func_e   br_func;

  id_latch u_id_latch (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_fs_to_ds_valid (i_fs_to_ds_valid),
    .i_fs_inst        (i_fs_inst),
    .i_fs_pc          (i_fs_pc),
    .i_es_allowin     (i_es_allowin),
    .i_load_stall     (load_stall),
    .o_ds_valid       (ds_valid),
    .o_inst           (ds_inst),
    .o_pc             (o_pc),
    .o_ds_allowin     (o_ds_allowin),
    .o_ds_to_es_valid (o_ds_to_es_valid)
  );

  idu u_idu (
    .i_inst         (ds_inst),
    .o_rs1          (rs1),
    .o_rs2          (rs2),
    .o_rd           (o_rd),
    .o_rs1_used     (rs1_used),
    .o_rs2_used     (rs2_used),
    .o_imm          (o_imm),
    .o_alu_op       (o_alu_op),
    .o_src1_sel     (o_src1_sel),
    .o_src2_sel     (o_src2_sel),
    .o_gpr_wen      (o_gpr_wen),
    .o_mem_ren      (o_mem_ren),
    .o_mem_wen      (o_mem_wen),
    .o_mem_op       (o_mem_op),
    .o_load_sel     (o_load_sel),
    .o_br_func      (br_func),
    .o_invalid_inst (o_invalid_inst)
  );

  gpr_file u_gpr_file (
    .i_clk    (i_clk),
    .i_raddr1 (rs1),
    .o_rdata1 (rf_rdata1),
    .i_raddr2 (rs2),
    .o_rdata2 (rf_rdata2),
    .i_wen    (i_rf_wen),
    .i_waddr  (i_rf_waddr),
    .i_wdata  (i_rf_wdata)
  );

  bypass_unit u_bypass_unit (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_ds_valid    (ds_valid),
    .i_rs1         (rs1),
    .i_rs2         (rs2),
    .i_rs1_used    (rs1_used),
    .i_rs2_used    (rs2_used),
    .i_rf_data1    (rf_rdata1),
    .i_rf_data2    (rf_rdata2),
    .i_es_rd       (i_es_rd),
    .i_es_result   (i_es_result),
    .i_ms_rd       (i_ms_rd),
    .i_ms_result   (i_ms_result),
    .i_ws_rd       (i_ws_rd),
    .i_ws_result   (i_ws_result),
    .i_es_load_sel (i_es_load_sel),
    .o_rs1_data    (o_rs1_data),
    .o_rs2_data    (o_rs2_data),
    .o_load_stall  (load_stall)
  );

  bru u_bru (
    .i_ds_valid   (ds_valid),
    .i_br_func    (br_func),
    .i_rs1_data   (o_rs1_data),
    .i_rs2_data   (o_rs2_data),
    .i_pc         (o_pc),
    .i_imm        (o_imm),
    .i_load_stall (load_stall),
    .o_br_taken   (o_br_taken),
    .o_br_target  (o_br_target),
    .o_br_stall   (o_br_stall)
  );

endmodule

//--- include/id_tb_checks.svh
// decode stage reference model
`ifndef ID_TB_CHECKS_SVH
`define ID_TB_CHECKS_SVH

typedef struct packed {
  rv_decode_pkg::gpr_addr_t rd;
  rv_decode_pkg::xlen_t     imm;
  logic [4:0]               alu;
  logic                     src1;
  logic [1:0]               src2;
  logic                     gpr_wen;
  logic                     mem_ren;
  logic                     mem_wen;
  logic [2:0]               mem_op;
  logic                     load_sel;
  logic                     invalid;
  rv_decode_pkg::xlen_t     rs1_data;
  rv_decode_pkg::xlen_t     rs2_data;
  logic                     br_taken;
  rv_decode_pkg::xlen_t     br_target;
  logic                     stall;
} exp_t;

task automatic fail_run(input string why);
  $display("%s", why);
  $display("SIMULATION FAILED");
  $fatal(1);
endtask

task automatic check_xlen(input string name, input rv_decode_pkg::xlen_t exp,
                          input rv_decode_pkg::xlen_t act);
  if (act !== exp) fail_run($sformatf("mismatch %s exp=%h act=%h", name, exp, act));
endtask

task automatic check_addr(input string name, input rv_decode_pkg::gpr_addr_t exp,
                          input rv_decode_pkg::gpr_addr_t act);
  if (act !== exp) fail_run($sformatf("mismatch %s exp=%h act=%h", name, exp, act));
endtask

// enums and enables, widened to 5 bits
task automatic check_ctrl(input string name, input logic [4:0] exp, input logic [4:0] act);
  if (act !== exp) fail_run($sformatf("mismatch %s exp=%h act=%h", name, exp, act));
endtask

// es, then ms, then ws, then register file
function automatic rv_decode_pkg::xlen_t operand(input rv_decode_pkg::gpr_addr_t rs);
  if (es_rd != 0 && rs == es_rd) return es_result;
  if (ms_rd != 0 && rs == ms_rd) return ms_result;
  if (ws_rd != 0 && rs == ws_rd) return ws_result;
  return (rs == 0) ? '0 : shadow[rs];
endfunction

function automatic exp_t ref_decode(input rv_decode_pkg::inst_t inst,
                                    input rv_decode_pkg::xlen_t pc);
  exp_t e;
  logic u1;
  logic u2;
  logic [2:0] f3;
  rv_decode_pkg::xlen_t a;
  rv_decode_pkg::xlen_t b;
  e = '0;
  e.alu = 5'd2;
  u1 = 1'b0;
  u2 = 1'b0;
  f3 = inst[14:12];
  a = operand(inst[19:15]);
  b = operand(inst[24:20]);
  case (inst[6:0])
    7'h13: begin  // addi
      e.imm = {{52{inst[31]}}, inst[31:20]};
      e.alu = 5'd0; e.src2 = 2'd1; e.gpr_wen = 1'b1; u1 = 1'b1;
    end
    7'h33: begin
      e.alu = (inst[31:25] == 7'h20) ? 5'd1 : 5'd0;
      e.gpr_wen = 1'b1; u1 = 1'b1; u2 = 1'b1;
    end
    7'h03: begin  // ld
      e.imm = {{52{inst[31]}}, inst[31:20]};
      e.alu = 5'd0; e.src2 = 2'd1; e.mem_op = 3'd3;
      e.gpr_wen = 1'b1; e.mem_ren = 1'b1; e.load_sel = 1'b1; u1 = 1'b1;
    end
    7'h23: begin  // sd
      e.imm = {{52{inst[31]}}, inst[31:25], inst[11:7]};
      e.alu = 5'd0; e.src2 = 2'd1; e.mem_op = 3'd3; e.mem_wen = 1'b1;
      u1 = 1'b1; u2 = 1'b1;
    end
    7'h63: begin
      e.imm = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      u1 = 1'b1; u2 = 1'b1;
      e.br_target = pc + e.imm;
      case (f3)
        3'd0: e.br_taken = (a == b);
        3'd1: e.br_taken = (a != b);
        3'd4: e.br_taken = ($signed(a) < $signed(b));
        default: e.br_taken = ($signed(a) >= $signed(b));
      endcase
    end
    7'h6f, 7'h67: begin
      e.alu = 5'd0; e.src1 = 1'b1; e.src2 = 2'd2; e.gpr_wen = 1'b1; e.br_taken = 1'b1;
      if (inst[6:0] == 7'h6f) begin
        e.imm = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        e.br_target = pc + e.imm;
      end else begin
        e.imm = {{52{inst[31]}}, inst[31:20]};
        u1 = 1'b1;
        e.br_target = (a + e.imm) & ~64'd1;
      end
    end
    default: e.invalid = 1'b1;
  endcase
  e.rd = e.gpr_wen ? inst[11:7] : '0;
  e.rs1_data = a;
  e.rs2_data = b;
  e.stall = es_load_sel && es_rd != 0 &&
            ((u1 && inst[19:15] == es_rd) || (u2 && inst[24:20] == es_rd));
  return e;
endfunction

`endif

//--- verification/id_stage_tb.sv
// decode stage testbench
`timescale 1ns/10ps

module id_stage_tb;

  localparam int N_INST = 300;
  localparam int N_INIT = 40;  // register preload cycles
  localparam int WATCHDOG_NS = (8 + N_INIT + N_INST * 20) * 10;

  logic clk = 1'b0;
  logic rst_n;
  logic fs_valid;
  rv_decode_pkg::inst_t inst_in;
  rv_decode_pkg::xlen_t pc_in;
  logic es_allowin;
  logic rf_wen;
  rv_decode_pkg::gpr_addr_t rf_waddr;
  rv_decode_pkg::xlen_t rf_wdata;
  rv_decode_pkg::gpr_addr_t es_rd, ms_rd, ws_rd;
  rv_decode_pkg::xlen_t es_result, ms_result, ws_result;
  logic es_load_sel;
  logic ds_allowin, ds_to_es_valid;
  rv_decode_pkg::xlen_t rs1_data, rs2_data, imm, pc_out, br_target;
  rv_decode_pkg::gpr_addr_t rd;
  rv_decode_pkg::alu_op_e alu_op;
  rv_decode_pkg::src1_sel_e src1_sel;
  rv_decode_pkg::src2_sel_e src2_sel;
  rv_decode_pkg::mem_op_e mem_op;
  logic gpr_wen, mem_ren, mem_wen, load_sel, invalid_inst, br_taken, br_stall;

  rv_decode_pkg::xlen_t shadow [32];
  rv_decode_pkg::inst_t cur_inst;
  rv_decode_pkg::xlen_t cur_pc;
  logic in_stage = 1'b0;

  `include "id_tb_checks.svh"

  id_stage dut (
    .i_clk(clk), .i_rst_n(rst_n), .i_fs_to_ds_valid(fs_valid), .i_fs_inst(inst_in),
    .i_fs_pc(pc_in), .o_ds_allowin(ds_allowin), .i_es_allowin(es_allowin),
    .o_ds_to_es_valid(ds_to_es_valid), .o_rs1_data(rs1_data), .o_rs2_data(rs2_data),
    .o_imm(imm), .o_pc(pc_out), .o_rd(rd), .o_alu_op(alu_op), .o_src1_sel(src1_sel),
    .o_src2_sel(src2_sel), .o_gpr_wen(gpr_wen), .o_mem_ren(mem_ren), .o_mem_wen(mem_wen),
    .o_mem_op(mem_op), .o_load_sel(load_sel), .o_invalid_inst(invalid_inst),
    .i_rf_wen(rf_wen), .i_rf_waddr(rf_waddr), .i_rf_wdata(rf_wdata),
    .i_es_rd(es_rd), .i_es_result(es_result), .i_ms_rd(ms_rd), .i_ms_result(ms_result),
    .i_ws_rd(ws_rd), .i_ws_result(ws_result), .i_es_load_sel(es_load_sel),
    .o_br_taken(br_taken), .o_br_stall(br_stall), .o_br_target(br_target)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    if (rf_wen && rf_waddr != 0) shadow[rf_waddr] <= rf_wdata;  // x0 stays zero
  end

  // compares at mid cycle
  always @(negedge clk) begin
    exp_t e;
    if (rst_n && !in_stage) begin
      check_ctrl("o_ds_to_es_valid", 5'd0, ds_to_es_valid);
      check_ctrl("o_br_taken", 5'd0, br_taken);
      check_ctrl("o_br_stall", 5'd0, br_stall);
      check_ctrl("o_ds_allowin", 5'd1, ds_allowin);
    end else if (rst_n) begin
      e = ref_decode(cur_inst, cur_pc);
      check_ctrl("o_ds_to_es_valid", !e.stall, ds_to_es_valid);
      check_ctrl("o_ds_allowin", !e.stall && es_allowin, ds_allowin);
      check_ctrl("o_br_taken", e.br_taken, br_taken);
      check_ctrl("o_br_stall", e.stall && e.br_taken, br_stall);
      if (e.br_taken) check_xlen("o_br_target", e.br_target, br_target);
      if (ds_to_es_valid) begin
        check_addr("o_rd", e.rd, rd);
        check_xlen("o_imm", e.imm, imm);
        check_xlen("o_pc", cur_pc, pc_out);
        check_xlen("o_rs1_data", e.rs1_data, rs1_data);
        check_xlen("o_rs2_data", e.rs2_data, rs2_data);
        check_ctrl("o_alu_op", e.alu, alu_op);
        check_ctrl("o_src1_sel", e.src1, src1_sel);
        check_ctrl("o_src2_sel", e.src2, src2_sel);
        check_ctrl("o_mem_op", e.mem_op, mem_op);
        check_ctrl("o_gpr_wen", e.gpr_wen, gpr_wen);
        check_ctrl("o_mem_ren", e.mem_ren, mem_ren);
        check_ctrl("o_mem_wen", e.mem_wen, mem_wen);
        check_ctrl("o_load_sel", e.load_sel, load_sel);
        check_ctrl("o_invalid_inst", e.invalid, invalid_inst);
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout, instruction never left decode");
    $display("SIMULATION FAILED");
    $fatal(1);
  end

  function automatic rv_decode_pkg::xlen_t rand64();
    return {$urandom, $urandom};
  endfunction

  function automatic rv_decode_pkg::inst_t random_inst();
    logic [4:0] r1, r2, rdx;
    logic [19:0] k;
    logic [6:0] bad_opc [5];
    logic [2:0] bf [4];
    bad_opc = '{7'h37, 7'h17, 7'h0f, 7'h73, 7'h1b};
    bf = '{3'd0, 3'd1, 3'd4, 3'd5};
    r1 = $urandom;
    r2 = $urandom;
    rdx = $urandom;
    k = $urandom;
    case ($urandom % 10)
      0: return {k[11:0], r1, 3'd0, rdx, 7'h13};
      1: return {7'h00, r2, r1, 3'd0, rdx, 7'h33};
      2: return {7'h20, r2, r1, 3'd0, rdx, 7'h33};
      3: return {k[11:0], r1, 3'd3, rdx, 7'h03};
      4: return {k[11:5], r2, r1, 3'd3, k[4:0], 7'h23};
      5, 6: return {k[6:0], r2, r1, bf[$urandom % 4], k[11:7], 7'h63};
      7: return {k, rdx, 7'h6f};
      8: return {k[11:0], r1, 3'd0, rdx, 7'h67};
      default: return {k, rdx, bad_opc[$urandom % 5]};
    endcase
  endfunction

  function automatic rv_decode_pkg::gpr_addr_t pick_rd(input rv_decode_pkg::inst_t i);
    case ($urandom % 4)
      0: return '0;
      1: return i[19:15];
      2: return i[24:20];
      default: return $urandom;
    endcase
  endfunction

  // mode 0 flows, 1 load-use stall, 2 back-pressure
  task automatic run_inst(input rv_decode_pkg::inst_t i, input rv_decode_pkg::xlen_t pc,
                          input int mode);
    int held;
    logic t0;
    rv_decode_pkg::xlen_t tgt0, a0, b0;
    held = 0;
    @(posedge clk);
    #1;
    fs_valid = 1'b1;
    inst_in = i;
    pc_in = pc;
    es_allowin = 1'b1;
    es_load_sel = 1'b0;
    rf_wen = $urandom % 2;
    rf_waddr = $urandom;
    rf_wdata = rand64();
    @(posedge clk);
    #1;
    cur_inst = i;
    cur_pc = pc;
    in_stage = 1'b1;
    fs_valid = 1'b0;
    rf_wen = 1'b0;
    es_rd = pick_rd(i);
    ms_rd = pick_rd(i);
    ws_rd = pick_rd(i);
    es_result = rand64();
    ms_result = rand64();
    ws_result = rand64();
    if (mode == 1) begin
      es_load_sel = 1'b1;
      es_rd = ($urandom % 2) ? i[19:15] : i[24:20];
    end
    if (mode == 2) begin
      es_allowin = 1'b0;
      fs_valid = 1'b1;  // fetch keeps offering while decode is blocked
      inst_in = ~i;
      pc_in = ~pc;
    end
    forever begin
      @(negedge clk);
      if (mode == 2 && held == 0) begin
        t0 = br_taken;
        tgt0 = br_target;
        a0 = rs1_data;
        b0 = rs2_data;
      end else if (mode == 2 && !es_allowin) begin
        check_ctrl("o_br_taken", t0, br_taken);
        check_xlen("o_br_target", tgt0, br_target);
        check_xlen("o_rs1_data", a0, rs1_data);
        check_xlen("o_rs2_data", b0, rs2_data);
      end
      if (ds_to_es_valid && es_allowin) begin
        @(posedge clk);
        #1;
        in_stage = 1'b0;
        es_load_sel = 1'b0;
        return;
      end
      @(posedge clk);
      #1;
      held++;
      if (held >= 3) begin
        es_load_sel = 1'b0;
        es_allowin = 1'b1;
        fs_valid = 1'b0;
      end
    end
  endtask

  initial begin
    void'($urandom(41));
    rst_n = 1'b0;
    fs_valid = 1'b0;
    inst_in = '0;
    pc_in = '0;
    es_allowin = 1'b1;
    rf_wen = 1'b0;
    rf_waddr = '0;
    rf_wdata = '0;
    es_rd = '0;
    ms_rd = '0;
    ws_rd = '0;
    es_result = '0;
    ms_result = '0;
    ws_result = '0;
    es_load_sel = 1'b0;
    shadow[0] = '0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // preload all registers and poke x0
    for (int r = 0; r < 32; r++) begin
      rf_wen = 1'b1;
      rf_waddr = r[4:0];
      rf_wdata = (r == 0) ? 64'hdead_beef : rand64();
      @(posedge clk);
      #1;
    end
    rf_wen = 1'b0;
    for (int n = 0; n < N_INST; n++) begin
      run_inst(random_inst(), rand64() & ~64'd3, $urandom % 3);
    end
    repeat (2) @(posedge clk);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

//--- all.f
+incdir+include
logic/rv_decode_pkg.sv
logic/id_latch.sv
logic/idu.sv
logic/gpr_file.sv
logic/bypass_unit.sv
logic/bru.sv
logic/id_stage.sv
verification/id_stage_tb.sv
